// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f build.f --top-module xrm_trigger_tb -o xrm_sim

run: build
	./obj_dir/xrm_sim | tee sim.log
	grep -q "Test passed" sim.log

lint:
	verilator --lint-only --timing -f build.f --top-module xrm_trigger_tb

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
design/xrm_timing_pkg.sv
design/xrm_wb_pkg.sv
design/xrm_buses_if.sv
design/xrm_config_regs.sv
design/orbit_framer.sv
design/bunch_marker_gen.sv
design/xrm_trigger_top.sv
dv/xrm_trigger_checker.sv
dv/xrm_trigger_tb.sv

// ==== design/bunch_marker_gen.sv ====
`timescale 1ns/1ns

module bunch_marker_gen (
	input logic clock127,
	input logic reset,
	orbit_if.marker orbit,
	marker_if.marker cfg,
	output logic fire
);
	// config snapshot for the current super-frame
	xrm_timing_pkg::bucket_t slot;
	xrm_timing_pkg::rev_mask_t mask;
	xrm_timing_pkg::count_t quantity;

	xrm_timing_pkg::count_t sent_count;
	logic active;
	logic below_quota;
	logic arm_allowed;
	logic match;

	// quantity of 0 never limits
	assign below_quota = (quantity == '0) || (sent_count < quantity);
	assign arm_allowed = (cfg.quantity == '0) || (sent_count < cfg.quantity);

	assign match = active && below_quota && (orbit.bucket == slot)
		&& |(mask & orbit.token);

	assign cfg.sent_count = sent_count;

	always_ff @(posedge clock127) begin
		if (orbit.superframe_end) begin
			slot <= cfg.slot;
			mask <= cfg.mask;
			quantity <= cfg.quantity;
		end
	end

	always_ff @(posedge clock127) begin
		if (reset) begin
			active <= 1'b0;
			fire <= 1'b0;
			sent_count <= '0;
		end else begin
			fire <= match; // one cycle after the slot
			if (orbit.superframe_end)
				active <= orbit.arm && arm_allowed; // else idle for this super-frame

			if (cfg.clear)
				sent_count <= '0; // clear beats a same-cycle trigger
			else if (match)
				sent_count <= sent_count + 1'b1;
		end
	end

endmodule

// ==== design/orbit_framer.sv ====
`timescale 1ns/1ns

module orbit_framer #(
	parameter int ORBIT_CLOCKS = xrm_timing_pkg::DEFAULT_ORBIT_CLOCKS
) (
	input logic clock127,
	input logic reset,
	input logic revo,
	input logic trigger_enable,
	input xrm_timing_pkg::prescale_log2_t prescale_log2,
	output logic frame,
	output logic frame9,
	output xrm_timing_pkg::count_t frame_count,
	output xrm_timing_pkg::count_t frame9_count,
	orbit_if.framer orbit
);
	xrm_timing_pkg::bucket_t bucket;
	xrm_timing_pkg::rev_token_t token;
	xrm_timing_pkg::count_t prescale_count; // super-frames since last arming
	xrm_timing_pkg::count_t prescale_target;
	logic wrap;
	logic superframe_end;
	logic arm;

	// revo restarts the orbit early
	assign wrap = revo || (bucket == xrm_timing_pkg::bucket_t'(ORBIT_CLOCKS - 1));
	assign superframe_end = wrap && token[0];
	assign prescale_target = xrm_timing_pkg::count_t'(1) << prescale_log2;
	assign arm = superframe_end && trigger_enable && (prescale_count >= prescale_target);

	assign orbit.bucket = bucket;
	assign orbit.token = token;
	assign orbit.superframe_end = superframe_end;
	assign orbit.arm = arm;

	always_ff @(posedge clock127) begin
		if (reset) begin
			bucket <= '0;
			token <= xrm_timing_pkg::TOKEN_RESET;
			frame <= 1'b0;
			frame9 <= 1'b0;
			frame_count <= '0;
			frame9_count <= '0;
			prescale_count <= xrm_timing_pkg::count_t'(1);
		end else begin
			frame <= wrap; // one cycle after the wrap
			if (wrap) begin
				bucket <= '0;
				token <= {token[0], token[$bits(token)-1:1]}; // rotate right
				frame9 <= token[0]; // bit 8 of the rotated token
				frame_count <= frame_count + 1'b1;
			end else begin
				bucket <= bucket + 1'b1;
			end

			if (superframe_end) begin
				frame9_count <= frame9_count + 1'b1;
				if (trigger_enable) begin
					if (arm)
						prescale_count <= xrm_timing_pkg::count_t'(1);
					else
						prescale_count <= prescale_count + 1'b1;
				end
			end
		end
	end

endmodule

// ==== design/xrm_buses_if.sv ====
`timescale 1ns/1ns

// orbit timing broadcast from the framer to every marker
interface orbit_if;
	xrm_timing_pkg::bucket_t bucket;
	xrm_timing_pkg::rev_token_t token;
	logic superframe_end; // wrap while token is at bit 0
	logic arm; // prescale complete and enabled

	modport framer (output bucket, token, superframe_end, arm);
	modport marker (input bucket, token, superframe_end, arm);
endinterface

// one marker's configuration and its sent count
interface marker_if;
	xrm_timing_pkg::bucket_t slot;
	xrm_timing_pkg::rev_mask_t mask;
	xrm_timing_pkg::count_t quantity; // 0 is unlimited
	logic clear; // one-cycle pulse
	xrm_timing_pkg::count_t sent_count;

	modport regs (output slot, mask, quantity, clear, input sent_count);
	modport marker (input slot, mask, quantity, clear, output sent_count);
endinterface

// ==== design/xrm_config_regs.sv ====
`timescale 1ns/1ns

module xrm_config_regs (
	input logic clock127,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input xrm_wb_pkg::wb_addr_t adr,
	input xrm_wb_pkg::wb_data_t dat_w,
	output xrm_wb_pkg::wb_data_t dat_r,
	output logic ack,
	output logic trigger_enable,
	output xrm_timing_pkg::prescale_log2_t prescale_log2,
	marker_if.regs markers [xrm_timing_pkg::NUM_MARKERS]
);
	localparam int N = xrm_timing_pkg::NUM_MARKERS;

	xrm_timing_pkg::bucket_t slot [N];
	xrm_timing_pkg::rev_mask_t mask [N];
	xrm_timing_pkg::count_t quantity [N];
	xrm_timing_pkg::count_t sent_count [N];
	logic [N-1:0] clear;
	logic request;
	xrm_wb_pkg::wb_data_t read_data;

	function automatic logic addr_hit(xrm_wb_pkg::wb_addr_t a, xrm_wb_pkg::wb_addr_t base, int i);
		return a == xrm_wb_pkg::wb_addr_t'(base + i);
	endfunction

	assign request = cyc && stb && !ack; // ack cycle is never a new request

	for (genvar i = 0; i < N; i++) begin : g_marker
		assign markers[i].slot = slot[i];
		assign markers[i].mask = mask[i];
		assign markers[i].quantity = quantity[i];
		assign markers[i].clear = clear[i];
		assign sent_count[i] = markers[i].sent_count;
	end

	always_comb begin
		read_data = '0; // unmapped addresses read as zero
		if (adr == xrm_wb_pkg::ADDR_CONTROL) begin
			read_data[xrm_wb_pkg::ENABLE_BIT] = trigger_enable;
			read_data[xrm_wb_pkg::PRESCALE_LSB +: $bits(prescale_log2)] = prescale_log2;
		end
		for (int i = 0; i < N; i++) begin
			if (addr_hit(adr, xrm_wb_pkg::ADDR_POSITION_BASE, i)) begin
				read_data[xrm_wb_pkg::SLOT_LSB +: $bits(slot[i])] = slot[i];
				read_data[xrm_wb_pkg::MASK_LSB +: $bits(mask[i])] = mask[i];
			end
			if (addr_hit(adr, xrm_wb_pkg::ADDR_QUANTITY_BASE, i))
				read_data = quantity[i];
			if (addr_hit(adr, xrm_wb_pkg::ADDR_SENT_BASE, i))
				read_data = sent_count[i];
		end
	end

	always_ff @(posedge clock127) begin
		if (reset) begin
			ack <= 1'b0;
			clear <= '0;
			trigger_enable <= 1'b0;
			prescale_log2 <= '0;
			for (int i = 0; i < N; i++) begin
				slot[i] <= '0;
				mask[i] <= '0;
				quantity[i] <= '0;
			end
		end else begin
			ack <= request;
			clear <= '0; // pulse lasts only the ack cycle
			if (request && we) begin
				if (adr == xrm_wb_pkg::ADDR_CONTROL) begin
					trigger_enable <= dat_w[xrm_wb_pkg::ENABLE_BIT];
					prescale_log2 <= dat_w[xrm_wb_pkg::PRESCALE_LSB +: $bits(prescale_log2)];
				end
				for (int i = 0; i < N; i++) begin
					if (addr_hit(adr, xrm_wb_pkg::ADDR_POSITION_BASE, i)) begin
						slot[i] <= dat_w[xrm_wb_pkg::SLOT_LSB +: $bits(slot[i])];
						mask[i] <= dat_w[xrm_wb_pkg::MASK_LSB +: $bits(mask[i])];
					end
					if (addr_hit(adr, xrm_wb_pkg::ADDR_QUANTITY_BASE, i))
						quantity[i] <= dat_w;
					if (addr_hit(adr, xrm_wb_pkg::ADDR_SENT_BASE, i))
						clear[i] <= 1'b1; // data ignored
				end
			end
		end
	end

	// captured with the request, held through ack
	always_ff @(posedge clock127) begin
		if (request)
			dat_r <= read_data;
	end

endmodule

// ==== design/xrm_timing_pkg.sv ====
package xrm_timing_pkg;

	localparam int REVS_PER_SUPERFRAME = 9;

	// position within one orbit, in clock127 cycles
	typedef logic [10:0] bucket_t;

	// one-hot, bit 8 is the first orbit of a super-frame and bit 0 the last
	typedef logic [REVS_PER_SUPERFRAME-1:0] rev_token_t;
	typedef logic [REVS_PER_SUPERFRAME-1:0] rev_mask_t; // same alignment as the token

	typedef logic [31:0] count_t; // frame, frame9, quantity and sent counts
	typedef logic [4:0] prescale_log2_t;

	localparam rev_token_t TOKEN_RESET = rev_token_t'(1) << (REVS_PER_SUPERFRAME - 1);

	localparam int NUM_MARKERS = 4; // fixed by the register map

	// 1280 buckets per beam orbit
	localparam int DEFAULT_ORBIT_CLOCKS = 1280;

endpackage

// ==== design/xrm_trigger_top.sv ====
`timescale 1ns/1ns

module xrm_trigger_top #(
	parameter int ORBIT_CLOCKS = xrm_timing_pkg::DEFAULT_ORBIT_CLOCKS
) (
	input logic clock127,
	input logic reset,
	input logic revo, // decoded single-cycle pulse
	input logic cyc,
	input logic stb,
	input logic we,
	input xrm_wb_pkg::wb_addr_t adr,
	input xrm_wb_pkg::wb_data_t dat_w,
	output xrm_wb_pkg::wb_data_t dat_r,
	output logic ack,
	output logic frame,
	output logic frame9,
	output logic xrm_trigger,
	output xrm_timing_pkg::count_t frame_count,
	output xrm_timing_pkg::count_t frame9_count
);
	logic trigger_enable;
	xrm_timing_pkg::prescale_log2_t prescale_log2;
	logic [xrm_timing_pkg::NUM_MARKERS-1:0] fire;

	orbit_if orbit_bus ();
	marker_if marker_bus [xrm_timing_pkg::NUM_MARKERS] ();

	xrm_config_regs config_regs_i (
		.clock127(clock127),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.trigger_enable(trigger_enable),
		.prescale_log2(prescale_log2),
		.markers(marker_bus)
	);

	orbit_framer #(.ORBIT_CLOCKS(ORBIT_CLOCKS)) orbit_framer_i (
		.clock127(clock127),
		.reset(reset),
		.revo(revo),
		.trigger_enable(trigger_enable),
		.prescale_log2(prescale_log2),
		.frame(frame),
		.frame9(frame9),
		.frame_count(frame_count),
		.frame9_count(frame9_count),
		.orbit(orbit_bus)
	);

	for (genvar i = 0; i < xrm_timing_pkg::NUM_MARKERS; i++) begin : g_marker
		bunch_marker_gen bunch_marker_i (
			.clock127(clock127),
			.reset(reset),
			.orbit(orbit_bus),
			.cfg(marker_bus[i]),
			.fire(fire[i])
		);
	end

	assign xrm_trigger = |fire; // any marker

endmodule

// ==== design/xrm_wb_pkg.sv ====
package xrm_wb_pkg;

	typedef logic [3:0] wb_addr_t; // word address
	typedef logic [31:0] wb_data_t;

	// register map, one word each
	localparam wb_addr_t ADDR_CONTROL = 4'd0;
	localparam wb_addr_t ADDR_POSITION_BASE = 4'd1; // 1 to 4
	localparam wb_addr_t ADDR_QUANTITY_BASE = 4'd5; // 5 to 8
	localparam wb_addr_t ADDR_SENT_BASE = 4'd9; // 9 to 12, write clears

	// control word
	localparam int ENABLE_BIT = 0;
	localparam int PRESCALE_LSB = 8; // bits 12:8

	// position word
	localparam int SLOT_LSB = 0; // bits 10:0
	localparam int MASK_LSB = 16; // bits 24:16

endpackage

// ==== dv/xrm_trigger_checker.sv ====
`timescale 1ns/1ns

module xrm_trigger_checker #(
	parameter int ORBIT = 64
) (
	input logic clock127,
	input logic reset,
	input logic revo,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [3:0] adr,
	input logic [31:0] dat_w,
	input logic [31:0] dat_r,
	input logic ack,
	input logic frame,
	input logic frame9,
	input logic xrm_trigger,
	input logic [31:0] frame_count,
	input logic [31:0] frame9_count,
	input logic test_end,
	output int error_count,
	output int tests_run,
	output int tests_failed
);
	logic enable;
	logic [4:0] prescale;
	logic [10:0] slot [4];
	logic [8:0] mask [4];
	int unsigned quantity [4];
	int unsigned armed [4]; // armed super-frames since last clear or reconfig
	int unsigned prior [4];
	int unsigned prescale_count;
	int pos, orbit_bit, idx, frames_seen, superframes_seen, since_superframe, test_errors;
	logic ack_prev, expect_frame, revo_in_orbit, frame9_prev, last_arm, hit;

	// popcount per armed super-frame, capped by a nonzero quantity
	function automatic int unsigned expected_sent(logic [8:0] m, int unsigned q,
			int unsigned a, int unsigned p);
		int unsigned total;
		total = p + $countones(m) * a;
		if (q != 0 && p >= q)
			return p; // exhausted, never armed again
		if (q != 0 && total > q)
			total = q;
		return total;
	endfunction

	function automatic logic [31:0] register_value(logic [3:0] a);
		if (a == 0)
			return {19'd0, prescale, 7'd0, enable};
		if (a >= 1 && a <= 4)
			return {7'd0, mask[a-1], 5'd0, slot[a-1]};
		if (a >= 5 && a <= 8)
			return quantity[a-5];
		if (a >= 9 && a <= 12)
			return expected_sent(mask[a-9], quantity[a-9], armed[a-9], prior[a-9]);
		return 0;
	endfunction

	task automatic value_error(string name, logic [31:0] got, logic [31:0] want);
		$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
		test_errors++;
		error_count++;
	endtask

	task automatic fault(string what);
		$display("Failure at %0t ns: %s", $time, what);
		test_errors++;
		error_count++;
	endtask

	always @(negedge clock127) begin
		if (reset) begin
			enable = 0;
			prescale = 0;
			for (int k = 0; k < 4; k++) begin
				slot[k] = 0;
				mask[k] = 0;
				quantity[k] = 0;
				armed[k] = 0;
				prior[k] = 0;
			end
			prescale_count = 1;
			{pos, frames_seen, superframes_seen, since_superframe} = '0;
			{error_count, tests_run, tests_failed, test_errors} = '0;
			orbit_bit = 8;
			{expect_frame, revo_in_orbit, frame9_prev, last_arm} = '0;
		end else begin
			if (ack && ack_prev)
				fault("ack held for more than one cycle");
			if (ack && !(cyc && stb))
				fault("ack without a request");
			if (ack && we) begin
				if (adr == 0) begin
					enable = dat_w[0];
					prescale = dat_w[12:8];
				end else if (adr <= 8) begin
					idx = (adr - 1) % 4;
					prior[idx] = expected_sent(mask[idx], quantity[idx], armed[idx], prior[idx]);
					armed[idx] = 0;
					if (adr <= 4) begin
						slot[idx] = dat_w[10:0];
						mask[idx] = dat_w[24:16];
					end else
						quantity[idx] = dat_w;
				end else if (adr <= 12) begin
					prior[adr-9] = 0; // sent count cleared
					armed[adr-9] = 0;
				end
			end else if (ack && dat_r !== register_value(adr))
				value_error($sformatf("dat_r (adr %0d)", adr), dat_r, register_value(adr));

			if (expect_frame && !frame)
				fault("no frame pulse one cycle after revo");
			expect_frame = revo;
			if (frame) begin
				frames_seen++;
				since_superframe++;
				if (frame_count != frames_seen)
					value_error("frame_count", frame_count, frames_seen);
				if (!revo_in_orbit && frames_seen > 1 && pos + 1 != ORBIT)
					fault($sformatf("orbit lasted %0d cycles instead of %0d", pos + 1, ORBIT));
				revo_in_orbit = 0;
				pos = 0;
				if (frame9) begin // wrap at the last orbit
					superframes_seen++;
					if (since_superframe != 9)
						fault($sformatf("super-frame of %0d orbits", since_superframe));
					since_superframe = 0;
					if (frame9_count != superframes_seen)
						value_error("frame9_count", frame9_count, superframes_seen);
					orbit_bit = 8;
					if (enable && prescale_count >= (32'd1 << prescale)) begin
						last_arm = 1;
						prescale_count = 1;
						for (int k = 0; k < 4; k++)
							armed[k]++;
					end else begin
						last_arm = 0;
						if (enable)
							prescale_count++;
					end
				end else
					orbit_bit = orbit_bit - 1;
			end else begin
				pos++;
				if (frame9 != frame9_prev)
					fault("frame9 changed in mid-orbit");
			end
			if (revo)
				revo_in_orbit = 1;
			frame9_prev = frame9;

			if (xrm_trigger) begin
				hit = 0;
				for (int k = 0; k < 4; k++)
					if (pos == slot[k] + 1 && mask[k][orbit_bit])
						hit = 1;
				if (!last_arm)
					fault("trigger in a super-frame that was not armed");
				else if (!hit)
					fault($sformatf("trigger at bucket %0d matches no marker", pos - 1));
			end

			if (test_end) begin
				tests_run++;
				if (test_errors != 0)
					tests_failed++;
				$display("test %0d finished with %0d errors", tests_run, test_errors);
				test_errors = 0;
			end
		end
		ack_prev = ack;
	end

endmodule

// ==== dv/xrm_trigger_tb.sv ====
`timescale 1ns/1ns

module xrm_trigger_tb;
	localparam int ORBIT_CLOCKS = 64;
	localparam int SEED = 73094;
	localparam int TEST_ORBITS = 260; // longest waits of all five tests
	localparam int WATCHDOG_CYCLES = TEST_ORBITS * ORBIT_CLOCKS + 2000;

	logic clock127, reset, revo, cyc, stb, we, ack;
	logic frame, frame9, xrm_trigger, test_end;
	logic [3:0] adr;
	logic [31:0] dat_w, dat_r, frame_count, frame9_count;
	int error_count, tests_run, tests_failed;

	xrm_trigger_top #(.ORBIT_CLOCKS(ORBIT_CLOCKS)) xrm_trigger_top_i (.*);
	xrm_trigger_checker #(.ORBIT(ORBIT_CLOCKS)) checker_i (.*);

	initial begin
		clock127 = 0;
		forever #50 clock127 = ~clock127;
	end

	initial begin
		#(WATCHDOG_CYCLES * 100);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	task automatic wb_access(input logic write, input logic [3:0] a, input logic [31:0] d);
		@(posedge clock127);
		cyc <= 1;
		stb <= 1;
		we <= write;
		adr <= a;
		dat_w <= d;
		do @(negedge clock127); while (!ack);
		@(posedge clock127);
		cyc <= 0;
		stb <= 0;
		we <= 0;
	endtask

	task automatic wait_frames(int n);
		repeat (n) do @(negedge clock127); while (!frame);
	endtask

	task automatic wait_superframes(int n);
		repeat (n) do @(negedge clock127); while (!(frame && frame9));
	endtask

	// written just after a frame, far from any wrap
	task automatic set_control(logic en, logic [4:0] p);
		wait_frames(1);
		wb_access(1, 0, {19'd0, p, 7'd0, en});
	endtask

	task automatic load_marker(int k, logic [10:0] s, logic [8:0] m, logic [31:0] q);
		wb_access(1, 4'(1 + k), {7'd0, m, 5'd0, s});
		wb_access(1, 4'(5 + k), q);
		wb_access(1, 4'(9 + k), 0);
	endtask

	task automatic load_random_markers();
		for (int k = 0; k < 4; k++)
			load_marker(k, 11'($urandom_range(0, 59)), 9'($urandom_range(1, 511)),
				$urandom_range(0, 12));
	endtask

	task automatic read_sent_counts();
		for (int k = 0; k < 4; k++)
			wb_access(0, 4'(9 + k), 0);
	endtask

	task automatic finish_test();
		@(posedge clock127);
		test_end <= 1;
		@(posedge clock127);
		test_end <= 0;
	endtask

	initial begin
		void'($urandom(SEED));
		{reset, revo, cyc, stb, we, test_end} = 6'b100000;
		adr = 0;
		dat_w = 0;
		repeat (8) @(posedge clock127);
		reset <= 0;

		// register access
		wb_access(1, 0, 32'hffff_1f01);
		wb_access(0, 0, 0);
		for (int k = 0; k < 4; k++) begin
			wb_access(1, 4'(1 + k), 32'hffff_ffff);
			wb_access(0, 4'(1 + k), 0);
			wb_access(1, 4'(5 + k), $urandom);
			wb_access(0, 4'(5 + k), 0);
		end
		wb_access(1, 0, 0);
		finish_test();

		// free-running orbit, then an early revo
		wait_frames(3);
		repeat (20) @(posedge clock127);
		revo <= 1;
		@(posedge clock127);
		revo <= 0;
		wait_frames(3);
		finish_test();

		wait_superframes(2);
		finish_test();

		// random markers, prescale 0 then 2
		load_random_markers();
		set_control(1, 0);
		wait_superframes(3);
		set_control(0, 0);
		wait_superframes(1);
		read_sent_counts();
		load_random_markers();
		set_control(1, 2);
		wait_superframes(9);
		set_control(0, 2);
		wait_superframes(1);
		read_sent_counts();
		finish_test();

		// quota exhaustion, clear and disable
		load_marker(0, 10, 9'h1ff, 2);
		load_marker(1, 30, 9'h111, 0); // unlimited marker keeps firing while enabled
		for (int k = 2; k < 4; k++)
			load_marker(k, 0, 0, 0);
		set_control(1, 0);
		wait_superframes(2);
		set_control(0, 0);
		wait_superframes(1);
		wb_access(0, 9, 0);
		wb_access(1, 9, 0);
		wb_access(0, 9, 0);
		set_control(1, 0);
		wait_superframes(2);
		set_control(0, 0);
		wait_superframes(1);
		wb_access(0, 9, 0);
		wait_superframes(2); // no triggers expected here
		wb_access(0, 10, 0);
		finish_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0 && tests_run == 5)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
